// ==== unified_l1_subsystem.f ====
+incdir+hw
hw/cache_types_pkg.sv
hw/mem_types_pkg.sv
hw/unified_l1_cache.sv
hw/writeback_buffer.sv
hw/main_memory.sv
hw/unified_l1_subsystem.sv
tb/tb_clock_gen.sv
tb/tb_unified_l1_subsystem.sv

// ==== Makefile ====
# Verilator build and run of the L1 subsystem testbench
SIM := obj_dir/Vtb_unified_l1_subsystem
SRCS := $(filter-out +%,$(shell cat unified_l1_subsystem.f)) hw/cache_consts.svh

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) unified_l1_subsystem.f
	verilator --binary --timing -j 0 --top-module tb_unified_l1_subsystem \
		-f unified_l1_subsystem.f

# a $fatal in the testbench gives a non-zero exit status
run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir

// ==== tb/tb_unified_l1_subsystem.sv ====
/* directed tests of the L1 subsystem against a word-level reference memory
   stops at the first mismatch; the run is bounded by a cycle limit */
`timescale 1ns/1ps
`include "cache_consts.svh"

module tb_unified_l1_subsystem;

	// about 250 requests, none longer than 14 cycles even with a dirty eviction
	localparam int TIMEOUT_CYCLES = 4000;
	localparam int HIT_CYCLES = 2;

	logic bus;
	logic reset;
	logic req;
	logic we;
	cache_types_pkg::addr_t addr;
	logic [`L1_WORD_BITS/8-1:0] byte_mask;
	cache_types_pkg::word_t wdata;
	logic ack;
	cache_types_pkg::word_t rdata;

	cache_types_pkg::word_t ref_mem [`MEM_WORDS];
	logic [15:0] lfsr_state;
	int cycle_count = 0;

	tb_clock_gen clock_gen (.bus(bus), .reset(reset));

	unified_l1_subsystem dut (
		.bus(bus), .reset(reset), .req(req), .we(we), .addr(addr),
		.byte_mask(byte_mask), .wdata(wdata), .ack(ack), .rdata(rdata)
	);

	always @(posedge bus) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("no response within %0d cycles, cache in %s, memory serving %s",
				TIMEOUT_CYCLES, dut.u_cache.state.name(), dut.u_memory.op.name());
			$display("TB FAILED");
			$fatal(1, "run stopped by the cycle limit");
		end
	end

	// 16-bit Galois LFSR, one step per bit taken
	function automatic logic random_bit();
		logic out;
		out = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (out)
			lfsr_state = lfsr_state ^ 16'hB400;
		return out;
	endfunction

	function automatic logic [31:0] random_bits(input int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++)
			value = {value[30:0], random_bit()};
		return value;
	endfunction

	// bytes with a mask bit set come from the new word
	function automatic cache_types_pkg::word_t apply_mask(
		input cache_types_pkg::word_t old_word,
		input cache_types_pkg::word_t new_word,
		input logic [3:0] mask
	);
		cache_types_pkg::word_t take_new;
		take_new = {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
		return (old_word & ~take_new) | (new_word & take_new);
	endfunction

	function automatic cache_types_pkg::addr_t word_addr(input int tag, input int index,
		input int offset);
		return {5'(tag), 4'(index), 1'(offset)};
	endfunction

	task automatic check_word(input string name, input cache_types_pkg::addr_t a,
		input cache_types_pkg::word_t got, input cache_types_pkg::word_t expected);
		if (got !== expected) begin
			$display("FAIL %s at addr 0x%h: got 0x%h, expected 0x%h", name, a, got, expected);
			$display("TB FAILED");
			$fatal(1, "data mismatch");
		end
	endtask

	task automatic check_hit_latency(input cache_types_pkg::addr_t a, input int got,
		input int expected);
		if (got != expected) begin
			$display("FAIL ack latency at addr 0x%h: got 0x%0h, expected 0x%0h", a, got,
				expected);
			$display("TB FAILED");
			$fatal(1, "hit latency mismatch");
		end
	endtask

	// one four-phase request, returns with the cache back in IDLE
	task automatic cpu_access(input logic is_write, input cache_types_pkg::addr_t a,
		input logic [3:0] mask, input cache_types_pkg::word_t data,
		output cache_types_pkg::word_t result, output int cycles);
		req = 1'b1;
		we = is_write;
		addr = a;
		byte_mask = mask;
		wdata = data;
		cycles = 0;
		do begin
			@(posedge bus);
			#1;
			cycles++;
		end while (!ack);
		result = rdata;
		req = 1'b0;
		do begin
			@(posedge bus);
			#1;
		end while (ack);
		// RELEASE takes one more cycle
		@(posedge bus);
		#1;
	endtask

	task automatic read_and_check(input cache_types_pkg::addr_t a, output int cycles);
		cache_types_pkg::word_t got;
		cpu_access(1'b0, a, 4'h0, '0, got, cycles);
		check_word("rdata", a, got, ref_mem[a]);
	endtask

	task automatic write_and_check(input cache_types_pkg::addr_t a, input logic [3:0] mask,
		input cache_types_pkg::word_t data, output int cycles);
		cache_types_pkg::word_t got;
		ref_mem[a] = apply_mask(ref_mem[a], data, mask);
		cpu_access(1'b1, a, mask, data, got, cycles);
		check_word("rdata", a, got, ref_mem[a]);
	endtask

	task automatic test_read_miss_then_hit();
		int c;
		read_and_check(word_addr(0, 9, 1), c);
		read_and_check(word_addr(0, 9, 1), c);
		check_hit_latency(word_addr(0, 9, 1), c, HIT_CYCLES);
	endtask

	task automatic test_masked_write_hit();
		int c;
		write_and_check(word_addr(0, 9, 1), 4'b0101, 32'h1122_3344, c);
		check_hit_latency(word_addr(0, 9, 1), c, HIT_CYCLES);
		read_and_check(word_addr(0, 9, 1), c);
	endtask

	task automatic test_write_miss_merge();
		int c;
		write_and_check(word_addr(5, 2, 0), 4'b1100, 32'hDEAD_BEEF, c);
		read_and_check(word_addr(5, 2, 1), c);
		read_and_check(word_addr(5, 2, 0), c);
	endtask

	// tags 1, 2 and 3 in set 3; touching tag 1 leaves tag 2 as the victim
	task automatic test_lru_eviction();
		int c;
		write_and_check(word_addr(1, 3, 0), 4'hF, 32'h1111_0000, c);
		write_and_check(word_addr(2, 3, 1), 4'b0110, 32'h2222_2222, c);
		read_and_check(word_addr(1, 3, 0), c);
		check_hit_latency(word_addr(1, 3, 0), c, HIT_CYCLES);
		read_and_check(word_addr(3, 3, 0), c);
		// tag 1 still hits, so tag 2 was the line that went out
		read_and_check(word_addr(1, 3, 0), c);
		check_hit_latency(word_addr(1, 3, 0), c, HIT_CYCLES);
		read_and_check(word_addr(2, 3, 1), c);
	endtask

	// dirty evictions back to back across sets 8 to 15
	task automatic test_back_pressure();
		int c;
		for (int t = 12; t < 15; t++) begin
			for (int s = 8; s < 16; s++)
				write_and_check(word_addr(t, s, s % 2), 4'hF, random_bits(32), c);
		end
		for (int t = 12; t < 14; t++) begin
			for (int s = 8; s < 16; s++)
				read_and_check(word_addr(t, s, s % 2), c);
		end
	endtask

	task automatic test_random_traffic();
		logic [31:0] pick;
		logic [31:0] mask_bits;
		cache_types_pkg::addr_t a;
		int c;
		for (int n = 0; n < 200; n++) begin
			pick = random_bits(6);
			// 4 tags over 8 sets, 64 words in all
			a = word_addr(16 + int'(pick[5:4]), int'(pick[3:1]), int'(pick[0]));
			if (random_bit()) begin
				mask_bits = random_bits(4);
				write_and_check(a, mask_bits[3:0], random_bits(32), c);
			end else begin
				read_and_check(a, c);
			end
		end
	endtask

	initial begin
		req = 1'b0;
		we = 1'b0;
		addr = '0;
		byte_mask = '0;
		wdata = '0;
		lfsr_state = 16'd70;
		// never-written words read as A5C3 over the zero-extended word address
		for (int i = 0; i < `MEM_WORDS; i++)
			ref_mem[i] = {16'hA5C3, 6'b0, 10'(i)};
		wait (reset === 1'b1);
		@(posedge bus);
		#1;
		test_read_miss_then_hit();
		test_masked_write_hit();
		test_write_miss_merge();
		test_lru_eviction();
		test_back_pressure();
		test_random_traffic();
		$display("TB PASSED");
		$finish;
	end

endmodule

// ==== tb/tb_clock_gen.sv ====
/* 10 ns clock on bus; reset is held low for the first 5 rising edges */
`timescale 1ns/1ps

module tb_clock_gen (
	output logic bus,
	output logic reset
);

	initial begin
		bus = 1'b0;
		forever #5 bus = ~bus;
	end

	// released a little after the edge, like every other stimulus
	initial begin
		reset = 1'b0;
		repeat (5) @(posedge bus);
		#1;
		reset = 1'b1;
	end

endmodule

// ==== hw/unified_l1_subsystem.sv ====
/* cache, write-back buffer and main memory behind one four-phase CPU port */
`timescale 1ns/1ps
`include "cache_consts.svh"

module unified_l1_subsystem (
	input  logic                       bus,
	input  logic                       reset,
	input  logic                       req,
	input  logic                       we,
	input  cache_types_pkg::addr_t     addr,
	input  logic [`L1_WORD_BITS/8-1:0] byte_mask,
	input  cache_types_pkg::word_t     wdata,
	output logic                       ack,
	output cache_types_pkg::word_t     rdata
);

	// cache to buffer
	logic wb_req;
	logic wb_ack;
	cache_types_pkg::line_t wb_line;
	cache_types_pkg::addr_t wb_addr;

	// buffer to memory
	logic drain_req;
	logic drain_ack;
	cache_types_pkg::line_t drain_line;
	cache_types_pkg::addr_t drain_addr;

	// cache to memory
	logic fill_req;
	logic fill_ack;
	cache_types_pkg::addr_t fill_addr;
	cache_types_pkg::word_t [`L1_LINE_WORDS-1:0] fill_data;

	unified_l1_cache u_cache (
		.bus(bus), .reset(reset),
		.req(req), .we(we), .addr(addr), .byte_mask(byte_mask), .wdata(wdata),
		.ack(ack), .rdata(rdata),
		.wb_req(wb_req), .wb_line(wb_line), .wb_addr(wb_addr), .wb_ack(wb_ack),
		.fill_req(fill_req), .fill_addr(fill_addr), .fill_ack(fill_ack),
		.fill_data(fill_data)
	);

	writeback_buffer u_wb_buffer (
		.bus(bus), .reset(reset),
		.wb_req(wb_req), .wb_line(wb_line), .wb_addr(wb_addr), .wb_ack(wb_ack),
		.drain_req(drain_req), .drain_line(drain_line), .drain_addr(drain_addr),
		.drain_ack(drain_ack)
	);

	main_memory u_memory (
		.bus(bus), .reset(reset),
		.drain_req(drain_req), .drain_line(drain_line), .drain_addr(drain_addr),
		.drain_ack(drain_ack),
		.fill_req(fill_req), .fill_addr(fill_addr), .fill_data(fill_data),
		.fill_ack(fill_ack)
	);

endmodule

// ==== hw/main_memory.sv ====
/* word memory, an unwritten word reads as A5C3 over its 16-bit address; a pending drain
   always goes before a fill, ack comes 2 cycles after the request */
`timescale 1ns/1ps
`include "cache_consts.svh"

module main_memory (
	input  logic                                        bus,
	input  logic                                        reset,
	input  logic                                        drain_req,
	input  cache_types_pkg::line_t                      drain_line,
	input  cache_types_pkg::addr_t                      drain_addr,
	output logic                                        drain_ack,
	input  logic                                        fill_req,
	input  cache_types_pkg::addr_t                      fill_addr,
	output cache_types_pkg::word_t [`L1_LINE_WORDS-1:0] fill_data,
	output logic                                        fill_ack
);

	localparam int MEM_AW = $clog2(`MEM_WORDS);

	cache_types_pkg::word_t mem [`MEM_WORDS];
	logic [`MEM_WORDS-1:0] written;
	mem_types_pkg::mem_state_t state;
	mem_types_pkg::mem_op_t op;
	logic do_drain;
	logic do_fill;

	function automatic cache_types_pkg::word_t read_word(input logic [MEM_AW-1:0] a);
		return written[a] ? mem[a] : {16'hA5C3, 16'(a)};
	endfunction

	assign do_drain = (state == mem_types_pkg::M_BUSY) && (op == mem_types_pkg::OP_DRAIN);
	assign do_fill = (state == mem_types_pkg::M_BUSY) && (op == mem_types_pkg::OP_FILL);

	// line words sit at consecutive addresses from the line base
	always_ff @(posedge bus) begin
		for (int i = 0; i < `L1_LINE_WORDS; i++) begin
			if (do_drain)
				mem[MEM_AW'(drain_addr) + MEM_AW'(i)] <= drain_line.data[i];
			if (do_fill)
				fill_data[i] <= read_word(MEM_AW'(fill_addr) + MEM_AW'(i));
		end
	end

	always_ff @(posedge bus) begin
		if (!reset) begin
			state <= mem_types_pkg::M_IDLE;
			op <= mem_types_pkg::OP_NONE;
			drain_ack <= 1'b0;
			fill_ack <= 1'b0;
			written <= '0;
		end else begin
			case (state)
				mem_types_pkg::M_IDLE: begin
					if (drain_req) begin
						op <= mem_types_pkg::OP_DRAIN;
						state <= mem_types_pkg::M_BUSY;
					end else if (fill_req) begin
						op <= mem_types_pkg::OP_FILL;
						state <= mem_types_pkg::M_BUSY;
					end
				end
				mem_types_pkg::M_BUSY: begin
					if (do_drain) begin
						drain_ack <= 1'b1;
						for (int i = 0; i < `L1_LINE_WORDS; i++)
							written[MEM_AW'(drain_addr) + MEM_AW'(i)] <= 1'b1;
					end else begin
						fill_ack <= 1'b1;
					end
					state <= mem_types_pkg::M_RELEASE;
				end
				mem_types_pkg::M_RELEASE: begin
					if ((op == mem_types_pkg::OP_DRAIN && !drain_req) ||
					    (op == mem_types_pkg::OP_FILL && !fill_req)) begin
						drain_ack <= 1'b0;
						fill_ack <= 1'b0;
						op <= mem_types_pkg::OP_NONE;
						state <= mem_types_pkg::M_IDLE;
					end
				end
				default: begin
					state <= mem_types_pkg::M_IDLE;
				end
			endcase
		end
	end

endmodule

// ==== hw/writeback_buffer.sv ====
/* FIFO of evicted dirty lines; a push is acked only when there is room
   drain_req drops as soon as drain_ack rises and returns once ack is low */
`timescale 1ns/1ps
`include "cache_consts.svh"

module writeback_buffer (
	input  logic                   bus,
	input  logic                   reset,
	input  logic                   wb_req,
	input  cache_types_pkg::line_t wb_line,
	input  cache_types_pkg::addr_t wb_addr,
	output logic                   wb_ack,
	output logic                   drain_req,
	output cache_types_pkg::line_t drain_line,
	output cache_types_pkg::addr_t drain_addr,
	input  logic                   drain_ack
);

	localparam int PTR_W = $clog2(`WB_DEPTH);

	cache_types_pkg::line_t lines [`WB_DEPTH];
	cache_types_pkg::addr_t addrs [`WB_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0] count;
	logic drain_ack_q;
	logic push;
	logic pop;

	assign push = wb_req && !wb_ack && (count != (PTR_W+1)'(`WB_DEPTH));
	// one pop per drain handshake, on the rising edge of its ack
	assign pop = drain_ack && !drain_ack_q;

	// head entry is offered until memory has taken it
	assign drain_req = (count != '0) && !drain_ack;
	assign drain_line = lines[rd_ptr];
	assign drain_addr = addrs[rd_ptr];

	always_ff @(posedge bus) begin
		if (!reset) begin
			wb_ack <= 1'b0;
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			drain_ack_q <= 1'b0;
		end else begin
			drain_ack_q <= drain_ack;
			if (push)
				wb_ack <= 1'b1;
			else if (!wb_req)
				wb_ack <= 1'b0;
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + (PTR_W+1)'(push) - (PTR_W+1)'(pop);
		end
	end

	always_ff @(posedge bus) begin
		if (push) begin
			lines[wr_ptr] <= wb_line;
			addrs[wr_ptr] <= wb_addr;
		end
	end

endmodule

// ==== hw/unified_l1_cache.sv ====
/* two-way write-back cache, one word per CPU request, inputs held stable while req is high
   a hit acks 2 cycles after req, a miss waits on the write-back buffer and the line fill */
`timescale 1ns/1ps
`include "cache_consts.svh"

module unified_l1_cache (
	input  logic                                           bus,
	input  logic                                           reset,
	input  logic                                           req,
	input  logic                                           we,
	input  cache_types_pkg::addr_t                         addr,
	input  logic [`L1_WORD_BITS/8-1:0]                     byte_mask,
	input  cache_types_pkg::word_t                         wdata,
	output logic                                           ack,
	output cache_types_pkg::word_t                         rdata,
	output logic                                           wb_req,
	output cache_types_pkg::line_t                         wb_line,
	output cache_types_pkg::addr_t                         wb_addr,
	input  logic                                           wb_ack,
	output logic                                           fill_req,
	output cache_types_pkg::addr_t                         fill_addr,
	input  logic                                           fill_ack,
	input  cache_types_pkg::word_t [`L1_LINE_WORDS-1:0]    fill_data
);

	localparam int SETS = 1 << `L1_INDEX_BITS;
	localparam int WAYS = `L1_WAYS;
	localparam int WAY_W = $clog2(`L1_WAYS);
	localparam int BYTES = `L1_WORD_BITS / 8;
	localparam logic [`L1_OFFSET_BITS-1:0] OFFSET_ZERO = '0;

	cache_types_pkg::line_t lines [SETS][WAYS];
	cache_types_pkg::cache_state_t state;

	cache_types_pkg::tag_t tag;
	logic [`L1_INDEX_BITS-1:0] index;
	logic [`L1_OFFSET_BITS-1:0] offset;

	logic hit;
	logic [WAY_W-1:0] hit_way;
	logic [WAY_W-1:0] victim_way;
	logic [WAY_W-1:0] victim_q;
	logic [WAY_W-1:0] touch_way;
	cache_types_pkg::lru_t lru_next [WAYS];

	cache_types_pkg::word_t hit_word;
	cache_types_pkg::word_t hit_merged;
	cache_types_pkg::word_t fill_merged;

	function automatic cache_types_pkg::word_t merge_word(
		input cache_types_pkg::word_t old_word,
		input cache_types_pkg::word_t new_word,
		input logic [BYTES-1:0] mask
	);
		cache_types_pkg::word_t result;
		result = old_word;
		for (int b = 0; b < BYTES; b++) begin
			if (mask[b])
				result[b*8 +: 8] = new_word[b*8 +: 8];
		end
		return result;
	endfunction

	assign {tag, index, offset} = addr;
	assign ack = (state == cache_types_pkg::RESPOND);

	// tag compare and LRU victim for the addressed set
	always_comb begin
		hit = 1'b0;
		hit_way = '0;
		victim_way = '0;
		for (int w = 0; w < WAYS; w++) begin
			if (lines[index][w].valid && lines[index][w].tag == tag) begin
				hit = 1'b1;
				hit_way = WAY_W'(w);
			end
			if (lines[index][w].lru == cache_types_pkg::lru_t'(WAYS - 1))
				victim_way = WAY_W'(w);
		end
	end

	// the touched way becomes MRU, younger ways age by one
	assign touch_way = (state == cache_types_pkg::LOOKUP) ? hit_way : victim_q;

	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			if (WAY_W'(w) == touch_way)
				lru_next[w] = '0;
			else if (lines[index][w].lru < lines[index][touch_way].lru)
				lru_next[w] = lines[index][w].lru + 1'b1;
			else
				lru_next[w] = lines[index][w].lru;
		end
	end

	assign hit_word = lines[index][hit_way].data[offset];
	assign hit_merged = merge_word(hit_word, wdata, byte_mask);
	assign fill_merged = merge_word(fill_data[offset], wdata, byte_mask);

	always_ff @(posedge bus) begin
		if (!reset) begin
			state <= cache_types_pkg::IDLE;
			wb_req <= 1'b0;
			fill_req <= 1'b0;
			for (int s = 0; s < SETS; s++) begin
				for (int w = 0; w < WAYS; w++) begin
					lines[s][w].valid <= 1'b0;
					lines[s][w].dirty <= 1'b0;
					lines[s][w].lru <= cache_types_pkg::lru_t'(w);
				end
			end
		end else begin
			case (state)
				cache_types_pkg::IDLE: begin
					if (req)
						state <= cache_types_pkg::LOOKUP;
				end
				cache_types_pkg::LOOKUP: begin
					if (hit) begin
						for (int w = 0; w < WAYS; w++)
							lines[index][w].lru <= lru_next[w];
						if (we) begin
							lines[index][hit_way].data[offset] <= hit_merged;
							lines[index][hit_way].dirty <= 1'b1;
							rdata <= hit_merged;
						end else begin
							rdata <= hit_word;
						end
						state <= cache_types_pkg::RESPOND;
					end else begin
						victim_q <= victim_way;
						// only dirty lines go back to memory
						if (lines[index][victim_way].valid && lines[index][victim_way].dirty) begin
							wb_req <= 1'b1;
							wb_line <= lines[index][victim_way];
							wb_addr <= {lines[index][victim_way].tag, index, OFFSET_ZERO};
							state <= cache_types_pkg::EVICT;
						end else begin
							state <= cache_types_pkg::FILL_REQ;
						end
					end
				end
				cache_types_pkg::EVICT: begin
					// stays here while the buffer is full
					if (wb_req) begin
						if (wb_ack)
							wb_req <= 1'b0;
					end else if (!wb_ack) begin
						state <= cache_types_pkg::FILL_REQ;
					end
				end
				cache_types_pkg::FILL_REQ: begin
					fill_req <= 1'b1;
					fill_addr <= {tag, index, OFFSET_ZERO};
					state <= cache_types_pkg::FILL_WAIT;
				end
				cache_types_pkg::FILL_WAIT: begin
					if (fill_req) begin
						if (fill_ack) begin
							fill_req <= 1'b0;
							for (int i = 0; i < `L1_LINE_WORDS; i++) begin
								if (we && i == int'(offset))
									lines[index][victim_q].data[i] <= fill_merged;
								else
									lines[index][victim_q].data[i] <= fill_data[i];
							end
							lines[index][victim_q].tag <= tag;
							lines[index][victim_q].valid <= 1'b1;
							lines[index][victim_q].dirty <= we;
							for (int w = 0; w < WAYS; w++)
								lines[index][w].lru <= lru_next[w];
							rdata <= we ? fill_merged : fill_data[offset];
						end
					end else if (!fill_ack) begin
						state <= cache_types_pkg::RESPOND;
					end
				end
				cache_types_pkg::RESPOND: begin
					if (!req)
						state <= cache_types_pkg::RELEASE;
				end
				cache_types_pkg::RELEASE: begin
					state <= cache_types_pkg::IDLE;
				end
				default: begin
					state <= cache_types_pkg::IDLE;
				end
			endcase
		end
	end

endmodule

// ==== hw/mem_types_pkg.sv ====
/* operation and handshake states of the main memory model */
package mem_types_pkg;

	// what the memory is serving right now
	typedef enum logic [1:0] {
		OP_NONE,
		OP_DRAIN,
		OP_FILL
	} mem_op_t;

	// one request at a time, ack held until the request falls
	typedef enum logic [1:0] {
		M_IDLE,
		M_BUSY,
		M_RELEASE
	} mem_state_t;

endpackage

// ==== hw/cache_types_pkg.sv ====
/* line format and controller states of the L1 cache; sizes come from cache_consts.svh */
`include "cache_consts.svh"

package cache_types_pkg;

	typedef logic [`L1_WORD_BITS-1:0] word_t;
	typedef logic [`L1_TAG_BITS-1:0] tag_t;
	typedef logic [$clog2(`L1_WAYS)-1:0] lru_t;

	// word address as seen on every port
	typedef logic [`L1_TAG_BITS+`L1_INDEX_BITS+`L1_OFFSET_BITS-1:0] addr_t;

	// lru 0 is the most recently used way
	typedef struct packed {
		lru_t lru;
		tag_t tag;
		logic valid;
		logic dirty;
		word_t [`L1_LINE_WORDS-1:0] data;
	} line_t;

	typedef enum logic [2:0] {
		IDLE,
		LOOKUP,
		EVICT,
		FILL_REQ,
		FILL_WAIT,
		RESPOND,
		RELEASE
	} cache_state_t;

endpackage

// ==== hw/cache_consts.svh ====
/* sizes for the L1 subsystem; word addresses are tag, index and offset packed into 10 bits
   WB_DEPTH must be a power of two of at least 2 */
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// data word and line shape
`define L1_WORD_BITS 32
`define L1_LINE_WORDS 2
`define L1_OFFSET_BITS 1

// set-associative geometry, 16 sets of 2 ways
`define L1_INDEX_BITS 4
`define L1_TAG_BITS 5
`define L1_WAYS 2

// backing store depth in words
`define MEM_WORDS 1024

// evicted lines waiting for memory
`define WB_DEPTH 2

`endif
